//--- include/sigencode_params.svh
// Shared constants of the ML-DSA z encoder
// Modulus and gamma1, coefficient and code widths, memory geometry
// and the APB address width
`ifndef SIGENCODE_PARAMS_SVH
`define SIGENCODE_PARAMS_SVH

// ML-DSA modulus and the bound of the z coefficients
`define SIG_Q          8380417
`define SIG_GAMMA1     524288
`define SIG_N          256

// Data widths
`define SIG_COEFF_W    24
`define SIG_Z_W        20

// Both memories hold four coefficients per word
`define SIG_ADDR_W     8
`define SIG_MEM_DEPTH  256
`define SIG_WORDS      64

`define SIG_APB_AW     4

`endif

//--- src/sigencode_pkg.sv
// Design types of the z encoder
// Coefficient, code and address vectors, memory word vectors,
// APB data and the engine state enum
`default_nettype none

`include "sigencode_params.svh"

package sigencode_pkg;

    typedef logic [`SIG_COEFF_W-1:0]   coeff_t;
    typedef logic [`SIG_Z_W-1:0]       zcode_t;
    typedef logic [`SIG_ADDR_W-1:0]    mem_addr_t;
    typedef logic [4*`SIG_COEFF_W-1:0] coeff_word_t;
    typedef logic [4*`SIG_Z_W-1:0]     zcode_word_t;
    typedef logic [31:0]               apb_data_t;

    // Reads lead writes by two cycles, so the middle states overlap them
    typedef enum logic [2:0] {
        IDLE,
        READ,
        READ_EXEC,
        READ_EXEC_WRITE,
        EXEC_WRITE,
        WRITE,
        DONE
    } enc_state_e;

endpackage

`default_nettype wire

//--- src/sigencode_z_unit.sv
// Single z encoder unit
// Registers gamma1 - c for one coefficient, as a 20-bit code
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module sigencode_z_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  sigencode_pkg::coeff_t data_i,
    output sigencode_pkg::zcode_t data_o
);
    import sigencode_pkg::*;

    localparam coeff_t GAMMA1 = coeff_t'(`SIG_GAMMA1);
    localparam coeff_t Q      = coeff_t'(`SIG_Q);

    coeff_t diff;

    // Values above gamma1 stand for the negative coefficient c - q
    always_comb begin
        if (data_i <= GAMMA1) begin
            diff = GAMMA1 - data_i;
        end else begin
            diff = GAMMA1 + Q - data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            data_o <= '0;
        end else if (zeroize) begin
            data_o <= '0;
        end else begin
            data_o <= diff[`SIG_Z_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/sigencode_z_engine.sv
// z encoding engine
// State machine with read and write pair counters, registered memory
// requests, eight encoder units and the done and busy status
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module sigencode_z_engine (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       start,
    input  sigencode_pkg::mem_addr_t   src_base,
    input  sigencode_pkg::mem_addr_t   dest_base,
    output logic                       rd_en_a,
    output sigencode_pkg::mem_addr_t   rd_addr_a,
    output logic                       rd_en_b,
    output sigencode_pkg::mem_addr_t   rd_addr_b,
    input  sigencode_pkg::coeff_word_t rd_data_a,
    input  sigencode_pkg::coeff_word_t rd_data_b,
    output logic                       wr_en_a,
    output sigencode_pkg::mem_addr_t   wr_addr_a,
    output sigencode_pkg::zcode_word_t wr_data_a,
    output logic                       wr_en_b,
    output sigencode_pkg::mem_addr_t   wr_addr_b,
    output sigencode_pkg::zcode_word_t wr_data_b,
    output logic                       busy,
    output logic                       done
);
    import sigencode_pkg::*;

    localparam int PAIR_W = $clog2(`SIG_WORDS / 2);
    localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(`SIG_WORDS / 2 - 1);

    enc_state_e        state;
    enc_state_e        next_state;
    logic [PAIR_W-1:0] rd_pair;
    logic [PAIR_W-1:0] wr_pair;
    mem_addr_t         src_lock;
    mem_addr_t         dest_lock;
    mem_addr_t         rd_off;
    mem_addr_t         wr_off;
    logic              reading;
    logic              writing;

    assign reading = (state == READ) || (state == READ_EXEC) || (state == READ_EXEC_WRITE);
    assign writing = (state == READ_EXEC_WRITE) || (state == EXEC_WRITE) || (state == WRITE);
    assign rd_off  = mem_addr_t'({rd_pair, 1'b0});
    assign wr_off  = mem_addr_t'({wr_pair, 1'b0});

    // ==========================================================
    // State machine
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            IDLE:            next_state = start ? READ : IDLE;
            READ:            next_state = READ_EXEC;
            READ_EXEC:       next_state = READ_EXEC_WRITE;
            // Leave once the last pair has been requested
            READ_EXEC_WRITE: next_state = (rd_pair == LAST_PAIR) ? EXEC_WRITE : READ_EXEC_WRITE;
            EXEC_WRITE:      next_state = WRITE;
            WRITE:           next_state = DONE;
            DONE:            next_state = IDLE;
            default:         next_state = IDLE;
        endcase
    end

    // ==========================================================
    // Counters, base capture and memory requests
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            rd_pair   <= '0;
            wr_pair   <= '0;
            src_lock  <= '0;
            dest_lock <= '0;
            rd_en_a   <= 1'b0;
            rd_en_b   <= 1'b0;
            rd_addr_a <= '0;
            rd_addr_b <= '0;
            wr_en_a   <= 1'b0;
            wr_en_b   <= 1'b0;
            wr_addr_a <= '0;
            wr_addr_b <= '0;
            done      <= 1'b0;
        end else begin
            if (state == IDLE && start) begin
                src_lock  <= src_base;
                dest_lock <= dest_base;
            end
            rd_pair   <= reading ? rd_pair + 1'b1 : '0;
            wr_pair   <= writing ? wr_pair + 1'b1 : '0;
            rd_en_a   <= reading;
            rd_en_b   <= reading;
            rd_addr_a <= reading ? src_lock + rd_off : '0;
            rd_addr_b <= reading ? src_lock + rd_off + mem_addr_t'(1) : '0;
            // Write data comes straight from the encoder registers
            wr_en_a   <= writing;
            wr_en_b   <= writing;
            wr_addr_a <= writing ? dest_lock + wr_off : '0;
            wr_addr_b <= writing ? dest_lock + wr_off + mem_addr_t'(1) : '0;
            done      <= (state == DONE);
        end
    end

    assign busy = (state != IDLE) || done;

    // Four encoders per read port
    for (genvar i = 0; i < 4; i++) begin : g_enc
        sigencode_z_unit enc_a_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .data_i  (rd_data_a[i*`SIG_COEFF_W +: `SIG_COEFF_W]),
            .data_o  (wr_data_a[i*`SIG_Z_W +: `SIG_Z_W])
        );
        sigencode_z_unit enc_b_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .data_i  (rd_data_b[i*`SIG_COEFF_W +: `SIG_COEFF_W]),
            .data_o  (wr_data_b[i*`SIG_Z_W +: `SIG_Z_W])
        );
    end

    assert property (@(posedge clk) disable iff (!reset_n) (state == IDLE) |-> !wr_en_a)
        else $error("signature write while the engine is idle");
    assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
        else $error("done pulse longer than one cycle");
    // The last word of the source polynomial ends the read requests
    assert property (@(posedge clk) disable iff (!reset_n)
        (rd_en_b && (rd_addr_b == mem_addr_t'(src_lock + (`SIG_WORDS - 1)))) |=> !rd_en_b)
        else $error("coefficient read beyond the source polynomial");

endmodule

`default_nettype wire

//--- src/coeff_mem.sv
// Coefficient memory
// One load port and two read ports with one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module coeff_mem (
    input  logic                       clk,
    input  logic                       load_en,
    input  sigencode_pkg::mem_addr_t   load_addr,
    input  sigencode_pkg::coeff_word_t load_data,
    input  logic                       rd_en_a,
    input  logic                       rd_en_b,
    input  sigencode_pkg::mem_addr_t   rd_addr_a,
    input  sigencode_pkg::mem_addr_t   rd_addr_b,
    output sigencode_pkg::coeff_word_t rd_data_a,
    output sigencode_pkg::coeff_word_t rd_data_b
);
    import sigencode_pkg::*;

    coeff_word_t mem [`SIG_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Read data holds its last value while a port is idle
    always_ff @(posedge clk) begin
        if (rd_en_a) begin
            rd_data_a <= mem[rd_addr_a];
        end
        if (rd_en_b) begin
            rd_data_b <= mem[rd_addr_b];
        end
    end

    assert property (@(posedge clk) load_en |-> !(rd_en_a || rd_en_b))
        else $error("coefficient load during an engine read");

endmodule

`default_nettype wire

//--- src/sig_mem.sv
// Signature memory
// Two write ports for the engine and a registered readback port
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module sig_mem (
    input  logic                       clk,
    input  logic                       wr_en_a,
    input  sigencode_pkg::mem_addr_t   wr_addr_a,
    input  sigencode_pkg::zcode_word_t wr_data_a,
    input  logic                       wr_en_b,
    input  sigencode_pkg::mem_addr_t   wr_addr_b,
    input  sigencode_pkg::zcode_word_t wr_data_b,
    input  sigencode_pkg::mem_addr_t   dump_addr,
    output sigencode_pkg::zcode_word_t dump_data
);
    import sigencode_pkg::*;

    zcode_word_t mem [`SIG_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_a) begin
            mem[wr_addr_a] <= wr_data_a;
        end
        if (wr_en_b) begin
            mem[wr_addr_b] <= wr_data_b;
        end
        dump_data <= mem[dump_addr];
    end

    assert property (@(posedge clk) (wr_en_a && wr_en_b) |-> (wr_addr_a != wr_addr_b))
        else $error("both signature write ports hit one address");

endmodule

`default_nettype wire

//--- src/sigencode_apb_regs.sv
// APB register block of the z encoder
// CTRL start and zeroize pulses, STATUS busy and sticky done,
// source and destination base registers
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module sigencode_apb_regs (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [`SIG_APB_AW-1:0]   paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  sigencode_pkg::apb_data_t pwdata,
    output sigencode_pkg::apb_data_t prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     busy,
    input  logic                     done,
    output logic                     start,
    output logic                     zeroize,
    output sigencode_pkg::mem_addr_t src_base,
    output sigencode_pkg::mem_addr_t dest_base
);
    import sigencode_pkg::*;

    localparam logic [`SIG_APB_AW-1:0] ADDR_CTRL   = `SIG_APB_AW'('h0);
    localparam logic [`SIG_APB_AW-1:0] ADDR_STATUS = `SIG_APB_AW'('h4);
    localparam logic [`SIG_APB_AW-1:0] ADDR_SRC    = `SIG_APB_AW'('h8);
    localparam logic [`SIG_APB_AW-1:0] ADDR_DEST   = `SIG_APB_AW'('hC);

    logic access;
    logic wr_ok;
    logic done_flag;

    // Every transfer completes in its access phase
    assign pready = 1'b1;
    assign access = psel && penable;

    // Unaligned addresses and reads of the write-only CTRL are not mapped
    assign pslverr = access && ((paddr[1:0] != 2'b00) || (!pwrite && paddr == ADDR_CTRL));
    assign wr_ok   = access && pwrite && !pslverr;

    always_comb begin
        case (paddr)
            ADDR_STATUS: prdata = {30'd0, done_flag, busy};
            ADDR_SRC:    prdata = apb_data_t'(src_base);
            ADDR_DEST:   prdata = apb_data_t'(dest_base);
            default:     prdata = '0;
        endcase
    end

    // ==========================================================
    // Register updates
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            start     <= 1'b0;
            zeroize   <= 1'b0;
            src_base  <= '0;
            dest_base <= '0;
            done_flag <= 1'b0;
        end else begin
            start   <= wr_ok && (paddr == ADDR_CTRL) && pwdata[0];
            zeroize <= wr_ok && (paddr == ADDR_CTRL) && pwdata[1];
            if (wr_ok && paddr == ADDR_SRC) begin
                src_base <= pwdata[`SIG_ADDR_W-1:0];
            end
            if (wr_ok && paddr == ADDR_DEST) begin
                dest_base <= pwdata[`SIG_ADDR_W-1:0];
            end
            // A finishing run wins over a clear in the same cycle
            if (done) begin
                done_flag <= 1'b1;
            end else if (wr_ok && paddr == ADDR_STATUS && pwdata[1]) begin
                done_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sigencode_subsys_top.sv
// Top level of the z encoder subsystem
// APB register block, encoding engine, coefficient memory and
// signature memory
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module sigencode_subsys_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [`SIG_APB_AW-1:0]     paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  sigencode_pkg::apb_data_t   pwdata,
    output sigencode_pkg::apb_data_t   prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       load_en,
    input  sigencode_pkg::mem_addr_t   load_addr,
    input  sigencode_pkg::coeff_word_t load_data,
    input  sigencode_pkg::mem_addr_t   dump_addr,
    output sigencode_pkg::zcode_word_t dump_data
);
    import sigencode_pkg::*;

    logic        start;
    logic        zeroize;
    logic        busy;
    logic        done;
    mem_addr_t   src_base;
    mem_addr_t   dest_base;
    logic        rd_en_a;
    logic        rd_en_b;
    mem_addr_t   rd_addr_a;
    mem_addr_t   rd_addr_b;
    coeff_word_t rd_data_a;
    coeff_word_t rd_data_b;
    logic        wr_en_a;
    logic        wr_en_b;
    mem_addr_t   wr_addr_a;
    mem_addr_t   wr_addr_b;
    zcode_word_t wr_data_a;
    zcode_word_t wr_data_b;

    sigencode_apb_regs sigencode_apb_regs_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .zeroize   (zeroize),
        .src_base  (src_base),
        .dest_base (dest_base)
    );

    sigencode_z_engine sigencode_z_engine_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .start     (start),
        .src_base  (src_base),
        .dest_base (dest_base),
        .rd_en_a   (rd_en_a),
        .rd_addr_a (rd_addr_a),
        .rd_en_b   (rd_en_b),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en_a   (wr_en_a),
        .wr_addr_a (wr_addr_a),
        .wr_data_a (wr_data_a),
        .wr_en_b   (wr_en_b),
        .wr_addr_b (wr_addr_b),
        .wr_data_b (wr_data_b),
        .busy      (busy),
        .done      (done)
    );

    coeff_mem coeff_mem_inst (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en_a   (rd_en_a),
        .rd_en_b   (rd_en_b),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    sig_mem sig_mem_inst (
        .clk       (clk),
        .wr_en_a   (wr_en_a),
        .wr_addr_a (wr_addr_a),
        .wr_data_a (wr_data_a),
        .wr_en_b   (wr_en_b),
        .wr_addr_b (wr_addr_b),
        .wr_data_b (wr_data_b),
        .dump_addr (dump_addr),
        .dump_data (dump_data)
    );

endmodule

`default_nettype wire

//--- sim/tb_sigencode.sv
// Testbench of the z encoder subsystem
// APB register tasks, coefficient loads and signature dumps,
// a reference model of the z encoding and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "sigencode_params.svh"

module tb_sigencode;
    import sigencode_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int GAMMA1     = `SIG_GAMMA1;
    localparam int Q          = `SIG_Q;
    localparam int RUNS       = 5;
    localparam int RUN_CYCLES = 36;
    localparam int WATCHDOG_CYCLES =
        RUNS * RUN_CYCLES + RUNS * (`SIG_WORDS + 2 * `SIG_MEM_DEPTH + 150) + 200;

    localparam logic [`SIG_APB_AW-1:0] ADDR_CTRL   = `SIG_APB_AW'('h0);
    localparam logic [`SIG_APB_AW-1:0] ADDR_STATUS = `SIG_APB_AW'('h4);
    localparam logic [`SIG_APB_AW-1:0] ADDR_SRC    = `SIG_APB_AW'('h8);
    localparam logic [`SIG_APB_AW-1:0] ADDR_DEST   = `SIG_APB_AW'('hC);

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic [`SIG_APB_AW-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    apb_data_t              pwdata;
    apb_data_t              prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   load_en;
    mem_addr_t              load_addr;
    coeff_word_t            load_data;
    mem_addr_t              dump_addr;
    zcode_word_t            dump_data;

    // Source polynomial and the expected signature memory content
    coeff_t      poly    [`SIG_N];
    zcode_word_t exp_sig [`SIG_MEM_DEPTH];
    logic        known   [`SIG_MEM_DEPTH];
    int          err_count = 0;
    apb_data_t   rdata;
    logic        rerr;
    mem_addr_t   src;
    mem_addr_t   dest;
    zcode_word_t bnd_exp;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sigencode_subsys_top sigencode_subsys_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dump_addr (dump_addr),
        .dump_data (dump_data)
    );

    // ==========================================================
    // Reporting and compare tasks
    // ==========================================================
    task automatic report_failure(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_zword(input string name, input zcode_word_t got, input zcode_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    // Stored values above gamma1 are negative coefficients c - q
    function automatic zcode_t z_model(input coeff_t c);
        int v;
        v = (int'(c) > GAMMA1) ? int'(c) - Q : int'(c);
        return zcode_t'(GAMMA1 - v);
    endfunction

    // Centered value in (-gamma1, gamma1], stored modulo q
    function automatic coeff_t rand_coeff();
        int v;
        v = int'($urandom % (2 * GAMMA1)) - GAMMA1 + 1;
        return (v < 0) ? coeff_t'(v + Q) : coeff_t'(v);
    endfunction

    function automatic coeff_word_t pack_word(input int w);
        return {poly[4*w+3], poly[4*w+2], poly[4*w+1], poly[4*w]};
    endfunction

    function automatic zcode_word_t model_word(input int w);
        return {z_model(poly[4*w+3]), z_model(poly[4*w+2]),
                z_model(poly[4*w+1]), z_model(poly[4*w])};
    endfunction

    // ==========================================================
    // Bus and memory port tasks
    // ==========================================================
    task automatic apb_xfer(input logic [`SIG_APB_AW-1:0] addr, input logic write,
                            input apb_data_t wdata, output apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_flag("pready", pready, 1'b1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [`SIG_APB_AW-1:0] addr, input apb_data_t data);
        apb_data_t unused;
        logic      err;
        apb_xfer(addr, 1'b1, data, unused, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic apb_read(input logic [`SIG_APB_AW-1:0] addr, output apb_data_t data);
        logic err;
        apb_xfer(addr, 1'b0, '0, data, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic fill_random();
        for (int j = 0; j < `SIG_N; j++) begin
            poly[j] = rand_coeff();
        end
    endtask

    task automatic load_poly(input mem_addr_t base);
        for (int w = 0; w < `SIG_WORDS; w++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= mem_addr_t'(base + w);
            load_data <= pack_word(w);
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic start_run(input mem_addr_t s, input mem_addr_t d);
        apb_data_t status;
        apb_write(ADDR_SRC, apb_data_t'(s));
        apb_write(ADDR_DEST, apb_data_t'(d));
        apb_write(ADDR_CTRL, 32'h1);
        apb_read(ADDR_STATUS, status);
        check_flag("STATUS.busy", status[0], 1'b1);
    endtask

    task automatic wait_done();
        apb_data_t status;
        int        polls;
        status = '0;
        for (polls = 0; polls < 40 && !status[1]; polls++) begin
            apb_read(ADDR_STATUS, status);
        end
        if (!status[1]) begin
            report_failure("Encoding run did not set STATUS.done in time");
        end
        check_reg("STATUS", status, 32'h2);
    endtask

    task automatic clear_done();
        apb_data_t status;
        apb_write(ADDR_STATUS, 32'h2);
        apb_read(ADDR_STATUS, status);
        check_reg("STATUS", status, 32'h0);
    endtask

    task automatic record_run(input mem_addr_t d);
        for (int w = 0; w < `SIG_WORDS; w++) begin
            exp_sig[mem_addr_t'(d + w)] = model_word(w);
            known[mem_addr_t'(d + w)]   = 1'b1;
        end
    endtask

    // Every word with a known value is dumped, inside and outside the last run
    task automatic check_sig();
        for (int a = 0; a < `SIG_MEM_DEPTH; a++) begin
            if (known[a]) begin
                @(posedge clk);
                dump_addr <= mem_addr_t'(a);
                @(posedge clk);
                @(negedge clk);
                check_zword($sformatf("dump_data[%0d]", a), dump_data, exp_sig[a]);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the test finished");
    end

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        void'($urandom(32'h9545));
        reset_n   = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dump_addr = '0;
        for (int a = 0; a < `SIG_MEM_DEPTH; a++) begin
            known[a] = 1'b0;
        end
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // Register state after reset
        apb_read(ADDR_STATUS, rdata);
        check_reg("STATUS", rdata, 32'h0);
        apb_read(ADDR_SRC, rdata);
        check_reg("SRC_BASE", rdata, 32'h0);
        apb_read(ADDR_DEST, rdata);
        check_reg("DEST_BASE", rdata, 32'h0);
        // 0x10 folds onto the write-only CTRL in a 4-bit decode
        apb_xfer(`SIG_APB_AW'('h10), 1'b0, '0, rdata, rerr);
        check_flag("pslverr", rerr, 1'b1);
        apb_xfer(`SIG_APB_AW'('h2), 1'b0, '0, rdata, rerr);
        check_flag("pslverr", rerr, 1'b1);
        apb_write(ADDR_SRC, 32'hA5);
        apb_read(ADDR_SRC, rdata);
        check_reg("SRC_BASE", rdata, 32'hA5);
        apb_write(ADDR_DEST, 32'h3C);
        apb_read(ADDR_DEST, rdata);
        check_reg("DEST_BASE", rdata, 32'h3C);

        // Random polynomial at random bases
        fill_random();
        src  = mem_addr_t'($urandom);
        dest = mem_addr_t'($urandom);
        load_poly(src);
        start_run(src, dest);
        wait_done();
        clear_done();
        record_run(dest);
        check_sig();

        // A second start while busy is ignored, even with a new DEST_BASE
        fill_random();
        src  = mem_addr_t'($urandom);
        dest = mem_addr_t'($urandom);
        load_poly(src);
        start_run(src, dest);
        apb_write(ADDR_DEST, apb_data_t'(mem_addr_t'(dest + 8'd64)));
        apb_write(ADDR_CTRL, 32'h1);
        wait_done();
        repeat (10) @(posedge clk);
        apb_read(ADDR_STATUS, rdata);
        check_reg("STATUS", rdata, 32'h2);
        clear_done();
        record_run(dest);
        check_sig();

        // Boundary coefficients 0, gamma1, q-gamma1+1 and q-1 in every word
        for (int j = 0; j < `SIG_N; j += 4) begin
            poly[j]   = coeff_t'(0);
            poly[j+1] = coeff_t'(GAMMA1);
            poly[j+2] = coeff_t'(Q - GAMMA1 + 1);
            poly[j+3] = coeff_t'(Q - 1);
        end
        bnd_exp = {zcode_t'(GAMMA1 + 1), zcode_t'((1 << `SIG_Z_W) - 1),
                   zcode_t'(0), zcode_t'(GAMMA1)};
        src  = mem_addr_t'($urandom);
        dest = mem_addr_t'($urandom);
        load_poly(src);
        start_run(src, dest);
        wait_done();
        clear_done();
        for (int w = 0; w < `SIG_WORDS; w++) begin
            exp_sig[mem_addr_t'(dest + w)] = bnd_exp;
            known[mem_addr_t'(dest + w)]   = 1'b1;
        end
        check_sig();

        // Zeroize in the middle of a run
        fill_random();
        src  = mem_addr_t'($urandom);
        dest = mem_addr_t'($urandom);
        load_poly(src);
        start_run(src, dest);
        apb_write(ADDR_CTRL, 32'h2);
        apb_read(ADDR_STATUS, rdata);
        check_reg("STATUS", rdata, 32'h0);
        repeat (RUN_CYCLES + 10) @(posedge clk);
        apb_read(ADDR_STATUS, rdata);
        check_reg("STATUS", rdata, 32'h0);
        // Part of the aborted destination range may have been written
        for (int w = 0; w < `SIG_WORDS; w++) begin
            known[mem_addr_t'(dest + w)] = 1'b0;
        end

        // Full run at new bases after zeroize
        fill_random();
        src  = mem_addr_t'($urandom);
        dest = mem_addr_t'($urandom);
        load_poly(src);
        start_run(src, dest);
        wait_done();
        clear_done();
        record_run(dest);
        check_sig();

        if (err_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure("Errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/sigencode_pkg.sv
src/sigencode_z_unit.sv
src/sigencode_z_engine.sv
src/coeff_mem.sv
src/sig_mem.sv
src/sigencode_apb_regs.sv
src/sigencode_subsys_top.sv
sim/tb_sigencode.sv

//--- Bender.yml
package:
  name: sigencode

sources:
  - include_dirs:
      - include
    files:
      - src/sigencode_pkg.sv
      - src/sigencode_z_unit.sv
      - src/sigencode_z_engine.sv
      - src/coeff_mem.sv
      - src/sig_mem.sv
      - src/sigencode_apb_regs.sv
      - src/sigencode_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_sigencode.sv
